/* common/distance_defs.svh */
// Word format shared by every block, unsigned Q(W-F).F
// F must not exceed W, and W + F must be even for the root
`ifndef DISTANCE_DEFS_SVH
`define DISTANCE_DEFS_SVH

// Width of coordinates, squares, sum and distance
`define DIST_BIT_WIDTH 32

// Fraction bits inside each word
`define DIST_F_BITS 16

`endif

/* common/distance_pkg.sv */
// Types shared by the distance RTL and its testbench
// Word width comes from the defs header, all values unsigned

`include "distance_defs.svh"

package distance_pkg;

  // ====================
  // Data words
  // ====================

  // One fixed-point value: coordinate, square or distance
  typedef logic [`DIST_BIT_WIDTH-1:0] word_t;

  // Input message, a sits in the upper word
  typedef struct packed {
    word_t a;
    word_t b;
  } point_t;

  // ====================
  // Controller
  // ====================

  typedef enum logic {
    ST_MULT = 1'b0,  // Squarers busy or done
    ST_SQRT = 1'b1   // Root running or result on output
  } dist_state_e;

endpackage

/* source/fxp_iter_multiplier.sv */
// Unsigned shift-add multiplier, one multiplier bit per cycle, n cycles per product
// Product is truncated by d bits and wraps to n bits, no rounding or overflow flag
`timescale 1ns/1ps

`include "distance_defs.svh"

module fxp_iter_multiplier #(
  parameter int n = `DIST_BIT_WIDTH,
  parameter int d = `DIST_F_BITS
) (
  input  logic                clk,
  input  logic                reset,

  input  logic                recv_val,
  output logic                recv_rdy,
  input  distance_pkg::word_t a,
  input  distance_pkg::word_t b,

  output logic                send_val,
  input  logic                send_rdy,
  output distance_pkg::word_t c
);

  import distance_pkg::*;

  localparam int CNT_W = (n > 1) ? $clog2(n) : 1;

  // Ports are word_t, so n has to match the package word
  if (n != $bits(word_t)) begin : g_width_check
    $error("fxp_iter_multiplier: n must equal the word width");
  end

  if (d > n) begin : g_frac_check
    $error("fxp_iter_multiplier: d must not exceed n");
  end

  // ====================
  // Control
  // ====================

  logic             busy;   // Iterating
  logic             done;   // Product waiting on send side
  logic [CNT_W-1:0] count;  // Iterations so far
  logic             accept;

  assign recv_rdy = !busy && !done;
  assign send_val = done;
  assign accept   = recv_val && recv_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else if (accept) begin
      busy  <= 1'b1;
      count <= '0;
    end else if (busy) begin
      count <= count + 1'b1;
      if (count == CNT_W'(n - 1)) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (done && send_rdy) begin
      done <= 1'b0;
    end
  end

  // ====================
  // Datapath
  // ====================

  logic [2*n-1:0] mcand;   // Multiplicand, shifts left
  logic [n-1:0]   mplier;  // Multiplier, shifts right
  logic [2*n-1:0] acc;     // Full 2n-bit product

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{n{1'b0}}, a};
      mplier <= b;
      acc    <= '0;
    end else if (busy) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // acc is frozen outside busy, so c holds until the next accept
  assign c = acc[d +: n];

  // ====================
  // Checks
  // ====================

  // Result and valid stay put while the consumer stalls
  a_hold_under_stall : assert property (
    @(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> (send_val && $stable(c))
  ) else $error("fxp_iter_multiplier: output changed under back-pressure");

endmodule

/* source/fxp_sqrt.sv */
// Unsigned digit-by-digit square root of a Q(W-F).F word, (W+F)/2 cycles per result
// Result is floor(sqrt(x * 2^F)), no rounding
`timescale 1ns/1ps

`include "distance_defs.svh"

module fxp_sqrt #(
  parameter int BIT_WIDTH = `DIST_BIT_WIDTH,
  parameter int F_BITS    = `DIST_F_BITS
) (
  input  logic                clk,
  input  logic                reset,

  input  logic                recv_val,
  output logic                recv_rdy,
  input  distance_pkg::word_t recv_msg,

  output logic                send_val,
  input  logic                send_rdy,
  output distance_pkg::word_t send_msg
);

  import distance_pkg::*;

  localparam int RAD_W = BIT_WIDTH + F_BITS;         // Radicand with fraction extension
  localparam int ITERS = RAD_W / 2;                  // One root bit per cycle
  localparam int REM_W = ITERS + 2;                  // Remainder, worst case
  localparam int CNT_W = (ITERS > 1) ? $clog2(ITERS) : 1;

  if (BIT_WIDTH != $bits(word_t)) begin : g_width_check
    $error("fxp_sqrt: BIT_WIDTH must equal the word width");
  end

  if ((RAD_W % 2) != 0 || F_BITS > BIT_WIDTH) begin : g_format_check
    $error("fxp_sqrt: BIT_WIDTH + F_BITS must be even and F_BITS <= BIT_WIDTH");
  end

  // ====================
  // Control
  // ====================

  logic             busy;
  logic             done;
  logic [CNT_W-1:0] count;
  logic             accept;

  assign recv_rdy = !busy && !done;
  assign send_val = done;
  assign accept   = recv_val && recv_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else if (accept) begin
      busy  <= 1'b1;
      count <= '0;
    end else if (busy) begin
      count <= count + 1'b1;
      if (count == CNT_W'(ITERS - 1)) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (done && send_rdy) begin
      done <= 1'b0;
    end
  end

  // ====================
  // Datapath
  // ====================

  logic [RAD_W-1:0] rad;    // Unconsumed radicand bits, top pair next
  logic [REM_W-1:0] rem;    // Partial remainder
  logic [ITERS-1:0] root;   // Root bits so far

  logic [REM_W-1:0] rem_shift;
  logic [REM_W-1:0] trial;
  logic [REM_W:0]   diff;   // Extra bit carries the sign
  logic             neg;

  // Bring down the next two radicand bits
  assign rem_shift = {rem[REM_W-3:0], rad[RAD_W-1 -: 2]};
  assign trial     = {root, 2'b01};  // 4 * root + 1
  assign diff      = {1'b0, rem_shift} - {1'b0, trial};
  assign neg       = diff[REM_W];

  always_ff @(posedge clk) begin
    if (accept) begin
      rad  <= {recv_msg, {F_BITS{1'b0}}};
      rem  <= '0;
      root <= '0;
    end else if (busy) begin
      rad  <= rad << 2;
      rem  <= neg ? rem_shift : diff[REM_W-1:0];
      root <= {root[ITERS-2:0], ~neg};  // New bit is 1 when trial fits
    end
  end

  // Root register is idle outside busy, so the result holds
  assign send_msg = word_t'(root);

  // ====================
  // Checks
  // ====================

  a_hold_under_stall : assert property (
    @(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> (send_val && $stable(send_msg))
  ) else $error("fxp_sqrt: output changed under back-pressure");

endmodule

/* distance_cal/distance_cal.sv */
// sqrt(a^2 + b^2) on unsigned fixed-point words with one point in flight at a time
// Squares and sum wrap modulo 2^W and all results are truncated
`timescale 1ns/1ps

`include "distance_defs.svh"

module distance_cal (
  input  logic                 clk,
  input  logic                 reset,

  input  distance_pkg::point_t recv_msg,
  input  logic                 recv_val,
  output logic                 recv_rdy,

  output distance_pkg::word_t  send_msg,
  output logic                 send_val,
  input  logic                 send_rdy
);

  import distance_pkg::*;

  dist_state_e state;
  dist_state_e state_next;

  // ====================
  // Squarers
  // ====================

  word_t a_sq;
  word_t b_sq;
  logic  a_recv_rdy, b_recv_rdy;
  logic  a_send_val, b_send_val;
  logic  mult_recv_val;
  logic  mult_send_rdy;

  // Only start both together, and only when the top accepts
  assign mult_recv_val = recv_val && recv_rdy;
  assign mult_send_rdy = (state == ST_MULT);

  fxp_iter_multiplier #(
    .n(`DIST_BIT_WIDTH),
    .d(`DIST_F_BITS)
  ) a_square (
    .clk     (clk),
    .reset   (reset),
    .recv_val(mult_recv_val),
    .recv_rdy(a_recv_rdy),
    .a       (recv_msg.a),
    .b       (recv_msg.a),
    .send_val(a_send_val),
    .send_rdy(mult_send_rdy),
    .c       (a_sq)
  );

  fxp_iter_multiplier #(
    .n(`DIST_BIT_WIDTH),
    .d(`DIST_F_BITS)
  ) b_square (
    .clk     (clk),
    .reset   (reset),
    .recv_val(mult_recv_val),
    .recv_rdy(b_recv_rdy),
    .a       (recv_msg.b),
    .b       (recv_msg.b),
    .send_val(b_send_val),
    .send_rdy(mult_send_rdy),
    .c       (b_sq)
  );

  // ====================
  // Sum and root
  // ====================

  word_t sum;
  logic  sqrt_recv_val, sqrt_recv_rdy;
  logic  sqrt_send_val, sqrt_send_rdy;
  logic  sqrt_fed;  // Root has taken the sum this pass

  assign sum = a_sq + b_sq;  // Wraps modulo 2^W and holds once the squarers hand off

  assign sqrt_recv_val = (state == ST_SQRT) && !sqrt_fed;
  assign sqrt_send_rdy = (state == ST_SQRT) && send_rdy;

  fxp_sqrt #(
    .BIT_WIDTH(`DIST_BIT_WIDTH),
    .F_BITS   (`DIST_F_BITS)
  ) root (
    .clk     (clk),
    .reset   (reset),
    .recv_val(sqrt_recv_val),
    .recv_rdy(sqrt_recv_rdy),
    .recv_msg(sum),
    .send_val(sqrt_send_val),
    .send_rdy(sqrt_send_rdy),
    .send_msg(send_msg)
  );

  // ====================
  // Controller
  // ====================

  assign recv_rdy = (state == ST_MULT) && a_recv_rdy && b_recv_rdy;
  assign send_val = (state == ST_SQRT) && sqrt_send_val;

  always_comb begin
    state_next = state;
    case (state)
      ST_MULT: if (a_send_val && b_send_val) state_next = ST_SQRT;
      ST_SQRT: if (send_val && send_rdy) state_next = ST_MULT;  // Output taken
      default: state_next = ST_MULT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_MULT;
      sqrt_fed <= 1'b0;
    end else begin
      state <= state_next;
      if (state_next == ST_MULT) begin
        sqrt_fed <= 1'b0;
      end else if (sqrt_recv_val && sqrt_recv_rdy) begin
        sqrt_fed <= 1'b1;
      end
    end
  end

  // ====================
  // Checks
  // ====================

  // One item in flight, so input and output never open together
  a_no_overlap : assert property (
    @(posedge clk) disable iff (reset)
    !(recv_rdy && send_val)
  ) else $error("distance_cal: recv_rdy and send_val high together");

endmodule

/* verification/distance_cal_tb.sv */
// Directed testbench for distance_cal, inputs driven on the falling edge
// Stops at the first mismatch or timeout
`timescale 1ns/1ps

`include "distance_defs.svh"

module distance_cal_tb;

  import distance_pkg::*;

  localparam int F_BITS = `DIST_F_BITS;
  localparam int TIMEOUT_CYCLES = 200;  // Well above W + 26 cycles of latency

  logic   clk;
  logic   reset;
  point_t recv_msg;
  logic   recv_val;
  logic   recv_rdy;
  word_t  send_msg;
  logic   send_val;
  logic   send_rdy;

  logic [31:0] lfsr_state;

  distance_cal distance_cal_inst (
    .clk     (clk),
    .reset   (reset),
    .recv_msg(recv_msg),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .send_msg(send_msg),
    .send_val(send_val),
    .send_rdy(send_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[$bits(word_t)-2:0], lfsr_state[31]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Square, wrap, then bit-by-bit integer root of sum * 2^F
  function automatic word_t model_distance(input word_t a, input word_t b);
    logic [63:0] sq_a;
    logic [63:0] sq_b;
    word_t       sum;
    logic [63:0] rad;
    logic [63:0] r;
    logic [63:0] cand;
    sq_a = (64'(a) * 64'(a)) >> F_BITS;
    sq_b = (64'(b) * 64'(b)) >> F_BITS;
    sum  = word_t'(sq_a) + word_t'(sq_b);
    rad  = 64'(sum) << F_BITS;
    r    = '0;
    for (int i = 31; i >= 0; i--) begin
      cand = r | (64'd1 << i);
      if (cand * cand <= rad) r = cand;
    end
    return word_t'(r);
  endfunction

  task automatic check_word(input string test, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Word mismatch in %s", test);
    end
  endtask

  task automatic check_bit(input string test, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %b, actual %b", test, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Flag mismatch in %s", test);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    $display("TEST FAILED");
    $fatal(1, "Wait limit reached");
  endtask

  // ====================
  // Handshakes
  // ====================

  // recv_rdy depends on state only, so it is steady through the low phase
  task automatic send_point(input word_t a, input word_t b);
    int cycles;
    @(negedge clk);
    recv_msg.a = a;
    recv_msg.b = b;
    recv_val   = 1'b1;
    cycles     = 0;
    while (!recv_rdy) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_timeout("recv_rdy");
    end
    @(negedge clk);  // Transfer happened on the edge just passed
    recv_val = 1'b0;
  endtask

  task automatic wait_send_val();
    int cycles;
    cycles = 0;
    while (!send_val) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_timeout("send_val");
    end
  endtask

  task automatic take_result(output word_t v);
    send_rdy = 1'b1;
    wait_send_val();
    v = send_msg;
    @(negedge clk);
    send_rdy = 1'b0;
  endtask

  task automatic run_point(input string name, input word_t a, input word_t b,
                           output word_t got);
    send_point(a, b);
    take_result(got);
    check_word(name, model_distance(a, b), got);
  endtask

  // ====================
  // Tests
  // ====================

  task automatic test_reset_state();
    @(negedge clk);
    check_bit("reset recv_rdy", 1'b1, recv_rdy);
    check_bit("reset send_val", 1'b0, send_val);
  endtask

  task automatic test_integer_points();
    word_t got;
    run_point("int (3,4)", 32'h0003_0000, 32'h0004_0000, got);
    check_word("int (3,4) value", 32'h0005_0000, got);
    run_point("int (0,0)", 32'h0, 32'h0, got);
    check_word("int (0,0) value", 32'h0, got);
    run_point("int (6,8)", 32'h0006_0000, 32'h0008_0000, got);
    check_word("int (6,8) value", 32'h000a_0000, got);
  endtask

  task automatic test_fraction_points();
    word_t got;
    run_point("frac (1.5,2.0)", 32'h0001_8000, 32'h0002_0000, got);
    check_word("frac (1.5,2.0) value", 32'h0002_8000, got);
    run_point("frac (0.25,0)", 32'h0000_4000, 32'h0, got);
    check_word("frac (0.25,0) value", 32'h0000_4000, got);
    run_point("frac (0.5,1.25)", 32'h0000_8000, 32'h0001_4000, got);
  endtask

  task automatic test_back_pressure();
    word_t a;
    word_t b;
    word_t held;
    word_t stall;
    take_bits(20, a);
    take_bits(20, b);
    take_bits(4, stall);  // 0..15, shifted to 5..20 below
    send_point(a, b);
    send_rdy = 1'b0;
    wait_send_val();
    held = send_msg;
    repeat (int'(stall) + 5) begin
      @(negedge clk);
      check_bit("stall send_val", 1'b1, send_val);
      check_word("stall send_msg", held, send_msg);
      check_bit("stall recv_rdy", 1'b0, recv_rdy);
    end
    send_rdy = 1'b1;
    @(negedge clk);
    send_rdy = 1'b0;
    check_word("stall result", model_distance(a, b), held);
    check_bit("after stall recv_rdy", 1'b1, recv_rdy);
  endtask

  task automatic test_random_sweep();
    word_t a;
    word_t b;
    word_t got;
    for (int i = 0; i < 50; i++) begin
      take_bits(23, a);  // 7 integer bits keep the sum under 2^31
      take_bits(23, b);
      run_point($sformatf("random %0d", i), a, b, got);
    end
  endtask

  task automatic test_back_to_back();
    word_t first;
    word_t got;
    send_point(32'h0005_0000, 32'h000c_0000);
    // Offer the next point at once, it must wait for the first result
    recv_msg.a = 32'h0008_0000;
    recv_msg.b = 32'h000f_0000;
    recv_val   = 1'b1;
    send_rdy   = 1'b0;
    for (int i = 0; !send_val; i++) begin
      check_bit("busy recv_rdy", 1'b0, recv_rdy);
      if (i > TIMEOUT_CYCLES) fail_timeout("first result of back-to-back pair");
      @(negedge clk);
    end
    first = send_msg;
    repeat (3) begin
      @(negedge clk);
      check_bit("held recv_rdy", 1'b0, recv_rdy);
    end
    send_rdy = 1'b1;
    @(negedge clk);
    send_rdy = 1'b0;
    check_word("first of pair", model_distance(32'h0005_0000, 32'h000c_0000), first);
    check_word("first of pair value", 32'h000d_0000, first);
    // Second point goes in on this cycle
    check_bit("second accept recv_rdy", 1'b1, recv_rdy);
    @(negedge clk);
    recv_val = 1'b0;
    take_result(got);
    check_word("second of pair", model_distance(32'h0008_0000, 32'h000f_0000), got);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    lfsr_state = 32'hd759_e83e;
    reset      = 1'b1;
    recv_msg   = '0;
    recv_val   = 1'b0;
    send_rdy   = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_integer_points();
    test_fraction_points();
    test_back_pressure();
    test_random_sweep();
    test_back_to_back();

    $display("TEST OK");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/distance_pkg.sv
source/fxp_iter_multiplier.sv
source/fxp_sqrt.sv
distance_cal/distance_cal.sv
verification/distance_cal_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the distance_cal testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module distance_cal_tb \
  -Mdir obj_dir \
  -f verilog.f

status=0
out=$(./obj_dir/Vdistance_cal_tb 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -q "TEST OK"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed (exit status $status)"
  exit 1
fi
